//--- sim/tcdm_stimulus.txt
# op port write addr data strb expected  (addr, data, strb, expected in hex; expected checked on reads)
# phase id max_gap  (starts once all ports drain; idle gaps of 0 to max_gap cycles)
# Port 0 fills all eight banks from rows 0 and 1, then reads back.
phase 1 0
op 0 1 00000000 a0000000 f 00000000
op 0 1 00000004 a1111111 f 00000000
op 0 1 00000008 a2222222 f 00000000
op 0 1 0000000c a3333333 f 00000000
op 0 1 00000020 a4444444 f 00000000
op 0 1 00000024 a5555555 f 00000000
op 0 1 00000028 a6666666 f 00000000
op 0 1 0000002c a7777777 f 00000000
op 0 0 00000000 00000000 0 a0000000
op 0 0 00000004 00000000 0 a1111111
op 0 0 00000008 00000000 0 a2222222
op 0 0 0000000c 00000000 0 a3333333
op 0 0 00000020 00000000 0 a4444444
op 0 0 00000024 00000000 0 a5555555
op 0 0 00000028 00000000 0 a6666666
op 0 0 0000002c 00000000 0 a7777777
# Byte strobes, lane 1 only.
phase 2 1
op 1 1 00000040 deadbeef f 00000000
op 1 1 00000040 00005500 2 00000000
op 1 0 00000040 00000000 0 dead55ef
# Same offset in rows 0 and 1, same cycle, different banks.
phase 3 0
op 0 0 00000000 00000000 0 a0000000
op 1 0 00000020 00000000 0 a4444444
# All ports on bank 0.
phase 4 0
op 0 1 00000000 c0c0c0c0 f 00000000
op 1 1 00000060 c1c1c1c1 f 00000000
op 2 1 00000080 c2c2c2c2 f 00000000
op 3 1 000000e0 c3c3c3c3 f 00000000
op 0 0 00000000 00000000 0 c0c0c0c0
op 1 0 00000060 00000000 0 c1c1c1c1
op 2 0 00000080 00000000 0 c2c2c2c2
op 3 0 000000e0 00000000 0 c3c3c3c3
# Mixed traffic with random gaps.
phase 5 3
op 0 1 00000100 11223344 f 00000000
op 1 1 00000124 55667788 f 00000000
op 2 1 00000148 99aabbcc f 00000000
op 3 1 0000016c ddeeff00 f 00000000
op 0 0 00000100 00000000 0 11223344
op 1 0 00000124 00000000 0 55667788
op 2 0 00000148 00000000 0 99aabbcc
op 3 0 0000016c 00000000 0 ddeeff00

//--- build.f
hdl/tcdm_pkg.sv
hdl/tcdm_rr_arbiter.sv
hdl/tcdm_xbar.sv
hdl/tcdm_bank.sv
hdl/tcdm_interconnect.sv
hdl/tcdm_subsystem.sv
sim/tcdm_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the TCDM testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tcdm_tb -o tcdm_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tcdm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

//--- sim/tcdm_tb.sv
// --------------------
// TCDM subsystem testbench.
// Clock and reset, stimulus file reader, per-port drivers,
// handshake and response monitor, latency and data checks.
// --------------------
`default_nettype none

module tcdm_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumInp       = 4;
  localparam int unsigned NumOut       = 8;
  localparam int unsigned MemAddrWidth = 6;
  localparam int unsigned Latency      = 1;
  localparam int unsigned ResetCycles  = 10;

  logic clk;
  logic rst;
  logic            [NumInp-1:0] req_valid;
  logic            [NumInp-1:0] req_ready;
  tcdm_pkg::addr_t [NumInp-1:0] req_addr;
  logic            [NumInp-1:0] req_write;
  tcdm_pkg::data_t [NumInp-1:0] req_data;
  tcdm_pkg::strb_t [NumInp-1:0] req_strb;
  logic            [NumInp-1:0] rsp_valid;
  tcdm_pkg::data_t [NumInp-1:0] rsp_data;

  // Operations as read from the file, indexed by line order.
  int              op_port  [$];
  int              op_phase [$];
  logic            op_write [$];
  tcdm_pkg::addr_t op_addr  [$];
  tcdm_pkg::data_t op_data  [$];
  tcdm_pkg::strb_t op_strb  [$];
  tcdm_pkg::data_t op_exp   [$];
  int              phase_gap [$];
  int              phase_num [$];

  // Per-port driver and scoreboard state.
  int          pend_q    [NumInp][$];
  int          exp_idx_q [NumInp][$];
  int unsigned exp_cyc_q [NumInp][$];
  int unsigned gap_cnt   [NumInp];
  int unsigned wait_cnt  [NumInp];
  logic [NumInp-1:0] active;
  logic [NumInp-1:0] hs_seen;
  int unsigned cycle = 0;
  int unsigned limit = 0;

  tcdm_subsystem #(
    .NumInp                (NumInp),
    .NumOut                (NumOut),
    .MemAddrWidth          (MemAddrWidth),
    .MemoryResponseLatency (Latency)
  ) dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_addr_i  (req_addr),
    .req_write_i (req_write),
    .req_data_i  (req_data),
    .req_strb_i  (req_strb),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data)
  );

  // --------------------
  // Helpers
  // --------------------
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "Run stopped on first error.");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      stop_with_error($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                                $time, what, actual, expected));
    end
  endtask

  // Bank of an address with word interleave and the half-row swap on row patterns 01 and 10.
  function automatic int unsigned bank_of(input tcdm_pkg::addr_t addr);
    int unsigned word;
    int unsigned row;
    int unsigned off;
    word = addr >> tcdm_pkg::ByteOffset;
    row  = word / NumOut;
    off  = word % NumOut;
    if (row % 4 == 1 || row % 4 == 2) begin
      off = (off + NumOut / 2) % NumOut;
    end
    return off;
  endfunction

  function automatic bit ports_idle();
    for (int i = 0; i < NumInp; i++) begin
      if (pend_q[i].size() != 0 || active[i] || exp_idx_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // One rising edge of every port driver.
  task automatic step_ports(input int unsigned max_gap);
    int idx;
    for (int i = 0; i < NumInp; i++) begin
      // Handshake seen at the last falling edge closes the operation.
      if (active[i] && hs_seen[i]) begin
        void'(pend_q[i].pop_front());
        active[i]  = 1'b0;
        gap_cnt[i] = $urandom % (max_gap + 1);
      end
      if (!active[i]) begin
        if (gap_cnt[i] > 0) begin
          gap_cnt[i]--;
        end else if (pend_q[i].size() > 0) begin
          idx = pend_q[i][0];
          req_addr[i]  <= op_addr[idx];
          req_write[i] <= op_write[idx];
          req_data[i]  <= op_data[idx];
          req_strb[i]  <= op_strb[idx];
          active[i] = 1'b1;
        end
      end
      req_valid[i] <= active[i];
    end
  endtask

  // --------------------
  // Clock, cycle count, timeout
  // --------------------
  initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin : cycle_count
    cycle <= cycle + 1;
    if (limit != 0 && cycle >= limit) begin
      stop_with_error($sformatf("Timeout: traffic did not drain within %0d cycles", limit));
    end
  end

  // --------------------
  // Monitor
  // --------------------
  // Sampled mid-cycle where requests and responses are stable.
  always @(negedge clk) begin : monitor
    int unsigned vld_cnt [NumOut];
    int unsigned rdy_cnt [NumOut];
    int unsigned bank;
    int unsigned hs;
    int idx;
    if (!rst) begin
      for (int j = 0; j < NumOut; j++) begin
        vld_cnt[j] = 0;
        rdy_cnt[j] = 0;
      end
      // Responses come in issue order one latency after the handshake cycle.
      for (int i = 0; i < NumInp; i++) begin
        if (rsp_valid[i]) begin
          if (exp_idx_q[i].size() == 0) begin
            stop_with_error($sformatf("Port %0d returned a response with none outstanding", i));
          end else begin
            idx = exp_idx_q[i].pop_front();
            hs  = exp_cyc_q[i].pop_front();
            check_equal(cycle - hs, Latency, $sformatf("port %0d response latency", i));
            if (!op_write[idx]) begin
              check_equal(rsp_data[i], op_exp[idx], $sformatf("port %0d read data", i));
            end
          end
        end
      end
      // Handshakes, waits and grants per bank.
      for (int i = 0; i < NumInp; i++) begin
        hs_seen[i] = req_valid[i] && req_ready[i];
        if (req_valid[i]) begin
          bank = bank_of(req_addr[i]);
          vld_cnt[bank]++;
          if (req_ready[i]) begin
            rdy_cnt[bank]++;
            exp_idx_q[i].push_back(pend_q[i][0]);
            exp_cyc_q[i].push_back(cycle);
            wait_cnt[i] = 0;
          end else begin
            wait_cnt[i]++;
            check_equal(wait_cnt[i] < NumInp ? 1 : 0, 1,
                        $sformatf("port %0d waited %0d cycles", i, wait_cnt[i]));
          end
        end
      end
      // A bank with requesters grants exactly one of them.
      for (int j = 0; j < NumOut; j++) begin
        if (vld_cnt[j] > 0) begin
          check_equal(rdy_cnt[j], 1, $sformatf("grants on bank %0d", j));
        end
      end
    end
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main
    int fd;
    int n;
    int num;
    int gap;
    int port;
    int wr;
    string line;
    string tag;
    tcdm_pkg::addr_t addr;
    tcdm_pkg::data_t data;
    tcdm_pkg::data_t expd;
    tcdm_pkg::strb_t strb;
    void'($urandom(48));
    rst       = 1'b1;
    req_valid = '0;
    req_addr  = '0;
    req_write = '0;
    req_data  = '0;
    req_strb  = '0;
    active    = '0;
    hs_seen   = '0;
    for (int i = 0; i < NumInp; i++) begin
      gap_cnt[i]  = 0;
      wait_cnt[i] = 0;
    end
    fd = $fopen("sim/tcdm_stimulus.txt", "r");
    if (fd == 0) begin
      stop_with_error("Could not open the stimulus file sim/tcdm_stimulus.txt");
    end
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%s", tag);
      if (n == 1 && tag == "phase") begin
        n = $sscanf(line, "%s %d %d", tag, num, gap);
        phase_num.push_back(num);
        phase_gap.push_back(gap);
      end else if (n == 1 && tag == "op") begin
        n = $sscanf(line, "%s %d %d %h %h %h %h", tag, port, wr, addr, data, strb, expd);
        if (n != 7 || port < 0 || port >= NumInp) begin
          stop_with_error($sformatf("Bad operation line in stimulus file: %s", line));
        end
        op_phase.push_back(phase_gap.size() - 1);
        op_port.push_back(port);
        op_write.push_back(wr != 0);
        op_addr.push_back(addr);
        op_data.push_back(data);
        op_strb.push_back(strb);
        op_exp.push_back(expd);
      end
    end
    $fclose(fd);
    limit = op_port.size() * NumInp * 4 + 200 + ResetCycles;

    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;

    for (int p = 0; p < phase_gap.size(); p++) begin
      // Queue this phase's operations per port in file order.
      for (int k = 0; k < op_port.size(); k++) begin
        if (op_phase[k] == p) begin
          pend_q[op_port[k]].push_back(k);
        end
      end
      for (int i = 0; i < NumInp; i++) begin
        gap_cnt[i] = 0;
      end
      $display("Phase %0d started at %0t ns", phase_num[p], $time);
      do begin
        @(posedge clk);
        step_ports(phase_gap[p]);
      end while (!ports_idle());
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/tcdm_subsystem.sv
// --------------------
// TCDM subsystem top level.
// Interconnect plus the bank array.
// --------------------
`default_nettype none

module tcdm_subsystem #(
  parameter int unsigned NumInp                = 4,
  parameter int unsigned NumOut                = 8,
  parameter int unsigned MemAddrWidth          = 6,
  parameter int unsigned MemoryResponseLatency = 1
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Requester request side.
  input  logic            [NumInp-1:0] req_valid_i,
  output logic            [NumInp-1:0] req_ready_o,
  input  tcdm_pkg::addr_t [NumInp-1:0] req_addr_i,
  input  logic            [NumInp-1:0] req_write_i,
  input  tcdm_pkg::data_t [NumInp-1:0] req_data_i,
  input  tcdm_pkg::strb_t [NumInp-1:0] req_strb_i,
  // Requester response side.
  output logic            [NumInp-1:0] rsp_valid_o,
  output tcdm_pkg::data_t [NumInp-1:0] rsp_data_o
);

  // Bank lines.
  logic            [NumOut-1:0]                   mem_req;
  logic            [NumOut-1:0]                   mem_we;
  logic            [NumOut-1:0][MemAddrWidth-1:0] mem_addr;
  tcdm_pkg::data_t [NumOut-1:0]                   mem_wdata;
  tcdm_pkg::strb_t [NumOut-1:0]                   mem_strb;
  tcdm_pkg::data_t [NumOut-1:0]                   mem_rdata;

  tcdm_interconnect #(
    .NumInp                (NumInp),
    .NumOut                (NumOut),
    .MemAddrWidth          (MemAddrWidth),
    .MemoryResponseLatency (MemoryResponseLatency)
  ) i_interconnect (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_write_i (req_write_i),
    .req_data_i  (req_data_i),
    .req_strb_i  (req_strb_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_strb_o  (mem_strb),
    .mem_rdata_i (mem_rdata)
  );

  // One bank per crossbar output.
  for (genvar j = 0; j < NumOut; j++) begin : gen_bank
    tcdm_bank #(
      .MemAddrWidth          (MemAddrWidth),
      .MemoryResponseLatency (MemoryResponseLatency)
    ) i_bank (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (mem_req[j]),
      .we_i    (mem_we[j]),
      .addr_i  (mem_addr[j]),
      .wdata_i (mem_wdata[j]),
      .strb_i  (mem_strb[j]),
      .rdata_o (mem_rdata[j])
    );
  end

endmodule

`default_nettype wire

//--- hdl/tcdm_interconnect.sv
// --------------------
// Fixed-latency TCDM interconnect.
// Row scramble and bank select, request crossbar,
// response steering through per-port delay lines.
// --------------------
`default_nettype none

module tcdm_interconnect #(
  parameter int unsigned NumInp                = 4,
  parameter int unsigned NumOut                = 8,
  parameter int unsigned MemAddrWidth          = 6,
  parameter int unsigned MemoryResponseLatency = 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // Requester request side.
  input  logic            [NumInp-1:0]                  req_valid_i,
  output logic            [NumInp-1:0]                  req_ready_o,
  input  tcdm_pkg::addr_t [NumInp-1:0]                  req_addr_i,
  input  logic            [NumInp-1:0]                  req_write_i,
  input  tcdm_pkg::data_t [NumInp-1:0]                  req_data_i,
  input  tcdm_pkg::strb_t [NumInp-1:0]                  req_strb_i,
  // Requester response side.
  output logic            [NumInp-1:0]                  rsp_valid_o,
  output tcdm_pkg::data_t [NumInp-1:0]                  rsp_data_o,
  // Bank side.
  output logic            [NumOut-1:0]                  mem_req_o,
  output logic            [NumOut-1:0]                  mem_we_o,
  output logic            [NumOut-1:0][MemAddrWidth-1:0] mem_addr_o,
  output tcdm_pkg::data_t [NumOut-1:0]                  mem_wdata_o,
  output tcdm_pkg::strb_t [NumOut-1:0]                  mem_strb_o,
  input  tcdm_pkg::data_t [NumOut-1:0]                  mem_rdata_i
);

  localparam int unsigned SelWidth  = $clog2(NumOut);
  // Byte offset bits inside one row.
  localparam int unsigned RowOffset = tcdm_pkg::ByteOffset + SelWidth;
  localparam int unsigned RowWidth  = tcdm_pkg::AddrWidth - RowOffset;

  typedef logic [SelWidth-1:0]     sel_t;
  typedef logic [RowWidth-1:0]     row_t;
  typedef logic [MemAddrWidth-1:0] mem_addr_t;

  // Half a row in words.
  localparam sel_t HalfRow = sel_t'(NumOut / 2);

  sel_t      [NumInp-1:0] bank_sel;
  mem_addr_t [NumInp-1:0] bank_addr;
  logic      [NumInp-1:0] handshake;

  // --------------------
  // Address mapping
  // --------------------
  for (genvar i = 0; i < NumInp; i++) begin : gen_addr_map
    row_t row;
    sel_t word_off;
    logic swap;

    assign row      = req_addr_i[i][tcdm_pkg::AddrWidth-1:RowOffset];
    assign word_off = req_addr_i[i][tcdm_pkg::ByteOffset +: SelWidth];
    assign swap     = tcdm_pkg::row_swapped(row[tcdm_pkg::RowPairBits-1:0]);

    // Swap half rows, wrap stays inside the row.
    assign bank_sel[i]  = swap ? word_off + HalfRow : word_off;
    // Row index becomes the word address inside the bank.
    assign bank_addr[i] = row[MemAddrWidth-1:0];
  end

  // --------------------
  // Request side
  // --------------------
  tcdm_xbar #(
    .NumInp       (NumInp),
    .NumOut       (NumOut),
    .MemAddrWidth (MemAddrWidth)
  ) i_xbar (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (req_valid_i),
    .ready_o     (req_ready_o),
    .sel_i       (bank_sel),
    .addr_i      (bank_addr),
    .we_i        (req_write_i),
    .wdata_i     (req_data_i),
    .strb_i      (req_strb_i),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_strb_o  (mem_strb_o)
  );

  assign handshake = req_valid_i & req_ready_o;

  // --------------------
  // Response side
  // --------------------
  // Latency is fixed, so a shift line of bank selects is enough.
  for (genvar i = 0; i < NumInp; i++) begin : gen_rsp
    sel_t [MemoryResponseLatency-1:0] sel_q;
    logic [MemoryResponseLatency-1:0] vld_q;

    always_ff @(posedge clk_i) begin : vld_line
      if (rst_i) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= handshake[i];
        for (int unsigned k = 1; k < MemoryResponseLatency; k++) begin
          vld_q[k] <= vld_q[k-1];
        end
      end
    end

    // Select payload follows the valid bits.
    always_ff @(posedge clk_i) begin : sel_line
      sel_q[0] <= bank_sel[i];
      for (int unsigned k = 1; k < MemoryResponseLatency; k++) begin
        sel_q[k] <= sel_q[k-1];
      end
    end

    assign rsp_valid_o[i] = vld_q[MemoryResponseLatency-1];
    assign rsp_data_o[i]  = mem_rdata_i[sel_q[MemoryResponseLatency-1]];
  end

endmodule

`default_nettype wire

//--- hdl/tcdm_bank.sv
// --------------------
// Single-port SRAM bank.
// Byte-strobed writes, read pipeline
// of MemoryResponseLatency stages.
// --------------------
`default_nettype none

module tcdm_bank #(
  parameter int unsigned MemAddrWidth          = 6,
  parameter int unsigned MemoryResponseLatency = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [MemAddrWidth-1:0] addr_i,
  input  tcdm_pkg::data_t         wdata_i,
  input  tcdm_pkg::strb_t         strb_i,
  output tcdm_pkg::data_t         rdata_o
);

  localparam int unsigned Depth = 2 ** MemAddrWidth;

  // Word storage.
  tcdm_pkg::data_t mem_q [Depth];
  // Read pipeline.
  tcdm_pkg::data_t [MemoryResponseLatency-1:0] rd_data_q;
  logic            [MemoryResponseLatency-1:0] rd_vld_q;
  logic                                        rd_en;

  assign rd_en = req_i && !we_i;

  // Only strobed byte lanes change.
  always_ff @(posedge clk_i) begin : write_port
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < tcdm_pkg::StrbWidth; b++) begin
        if (strb_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Stages load only behind a read.
  always_ff @(posedge clk_i) begin : read_pipe
    if (rd_en) begin
      rd_data_q[0] <= mem_q[addr_i];
    end
    for (int unsigned k = 1; k < MemoryResponseLatency; k++) begin
      if (rd_vld_q[k-1]) begin
        rd_data_q[k] <= rd_data_q[k-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin : read_vld
    if (rst_i) begin
      rd_vld_q <= '0;
    end else begin
      rd_vld_q[0] <= rd_en;
      for (int unsigned k = 1; k < MemoryResponseLatency; k++) begin
        rd_vld_q[k] <= rd_vld_q[k-1];
      end
    end
  end

  // Quiet bus when no read is at the tail.
  assign rdata_o = rd_vld_q[MemoryResponseLatency-1] ?
                   rd_data_q[MemoryResponseLatency-1] : '0;

endmodule

`default_nettype wire

//--- hdl/tcdm_xbar.sv
// --------------------
// Request crossbar.
// Bank select decode, one arbiter per bank,
// payload multiplexing and ready return.
// --------------------
`default_nettype none

module tcdm_xbar #(
  parameter int unsigned NumInp       = 4,
  parameter int unsigned NumOut       = 8,
  parameter int unsigned MemAddrWidth = 6
) (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  // Requester side, one entry per port.
  input  logic            [NumInp-1:0]                    valid_i,
  output logic            [NumInp-1:0]                    ready_o,
  input  logic            [NumInp-1:0][$clog2(NumOut)-1:0] sel_i,
  input  logic            [NumInp-1:0][MemAddrWidth-1:0]   addr_i,
  input  logic            [NumInp-1:0]                    we_i,
  input  tcdm_pkg::data_t [NumInp-1:0]                    wdata_i,
  input  tcdm_pkg::strb_t [NumInp-1:0]                    strb_i,
  // Bank side, one entry per bank.
  output logic            [NumOut-1:0]                    mem_req_o,
  output logic            [NumOut-1:0]                    mem_we_o,
  output logic            [NumOut-1:0][MemAddrWidth-1:0]   mem_addr_o,
  output tcdm_pkg::data_t [NumOut-1:0]                    mem_wdata_o,
  output tcdm_pkg::strb_t [NumOut-1:0]                    mem_strb_o
);

  typedef logic [$clog2(NumOut)-1:0] sel_t;
  typedef logic [MemAddrWidth-1:0]   mem_addr_t;

  // Grant matrix, bank by port.
  logic [NumOut-1:0][NumInp-1:0] gnt;

  // --------------------
  // Per-bank arbitration
  // --------------------
  for (genvar j = 0; j < NumOut; j++) begin : gen_bank
    logic [NumInp-1:0] bank_req;
    logic              bank_we;
    mem_addr_t         bank_addr;
    tcdm_pkg::data_t   bank_wdata;
    tcdm_pkg::strb_t   bank_strb;

    // Ports that target this bank.
    for (genvar i = 0; i < NumInp; i++) begin : gen_decode
      assign bank_req[i] = valid_i[i] && (sel_i[i] == sel_t'(j));
    end

    tcdm_rr_arbiter #(
      .NumInp (NumInp)
    ) i_arbiter (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (bank_req),
      .gnt_o   (gnt[j]),
      .valid_o (mem_req_o[j])
    );

    // AND-OR mux on the one-hot grant.
    always_comb begin : mux_payload
      bank_we    = 1'b0;
      bank_addr  = '0;
      bank_wdata = '0;
      bank_strb  = '0;
      for (int unsigned i = 0; i < NumInp; i++) begin
        if (gnt[j][i]) begin
          bank_we    = bank_we | we_i[i];
          bank_addr  = bank_addr | addr_i[i];
          bank_wdata = bank_wdata | wdata_i[i];
          bank_strb  = bank_strb | strb_i[i];
        end
      end
    end

    assign mem_we_o[j]    = bank_we;
    assign mem_addr_o[j]  = bank_addr;
    assign mem_wdata_o[j] = bank_wdata;
    assign mem_strb_o[j]  = bank_strb;
  end

  // --------------------
  // Ready return
  // --------------------
  // A port is ready when its own bank grants it.
  for (genvar i = 0; i < NumInp; i++) begin : gen_ready
    assign ready_o[i] = gnt[sel_i[i]][i];
  end

endmodule

`default_nettype wire

//--- hdl/tcdm_rr_arbiter.sv
// --------------------
// Round-robin arbiter for one bank.
// A grant completes its handshake in its own cycle.
// --------------------
`default_nettype none

module tcdm_rr_arbiter #(
  parameter int unsigned NumInp = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [NumInp-1:0] req_i,
  output logic [NumInp-1:0] gnt_o,
  output logic              valid_o
);

  localparam int unsigned IdxWidth = (NumInp > 1) ? $clog2(NumInp) : 1;
  typedef logic [IdxWidth-1:0] idx_t;

  // Highest priority index for the next decision.
  idx_t ptr_q, ptr_d;
  // Encoded index of the current grant.
  idx_t gnt_idx;
  // Round-robin choice.
  logic [NumInp-1:0] rr_gnt;

  // First requester at or after the pointer, wrapping.
  always_comb begin : find_winner
    int unsigned cand;
    logic found;
    rr_gnt = '0;
    found  = 1'b0;
    for (int unsigned k = 0; k < NumInp; k++) begin
      cand = (ptr_q + k) % NumInp;
      if (!found && req_i[cand]) begin
        found        = 1'b1;
        rr_gnt[cand] = 1'b1;
      end
    end
  end

  // The granted port sees ready in the same cycle.
  // Banks always accept, so every grant is also a handshake.
  assign gnt_o   = rr_gnt;
  assign valid_o = |gnt_o;

  // One-hot to index.
  always_comb begin : encode_grant
    gnt_idx = '0;
    for (int unsigned k = 0; k < NumInp; k++) begin
      if (gnt_o[k]) begin
        gnt_idx = idx_t'(k);
      end
    end
  end

  // Next pointer sits just past the winner.
  assign ptr_d = (gnt_idx == idx_t'(NumInp - 1)) ? '0 : gnt_idx + idx_t'(1);

  always_ff @(posedge clk_i) begin : arb_state
    if (rst_i) begin
      ptr_q <= '0;
    end else begin
      // Advance only on a completed transfer.
      if (valid_o) begin
        ptr_q <= ptr_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/tcdm_pkg.sv
// --------------------
// Shared TCDM definitions.
// Requester word layout, payload vector types
// and the row scramble constants.
// --------------------
`default_nettype none

package tcdm_pkg;

  // --------------------
  // Requester word layout
  // --------------------

  // Byte address width on the requester side.
  localparam int unsigned AddrWidth = 32;

  // Data word width.
  localparam int unsigned DataWidth = 32;

  // One strobe per byte lane.
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Byte offset bits below the word index.
  localparam int unsigned ByteOffset = $clog2(StrbWidth);

  // Requester byte address.
  typedef logic [AddrWidth-1:0] addr_t;

  // One data word.
  typedef logic [DataWidth-1:0] data_t;

  // Byte enables of one word.
  typedef logic [StrbWidth-1:0] strb_t;

  // --------------------
  // Row scramble
  // --------------------

  // Low row index bits that select the scramble pattern.
  localparam int unsigned RowPairBits = 2;

  // Row patterns whose two half rows trade places.
  // Rows 1 and 2 of every group of four are swapped,
  // so rows 0/1 and 2/3 never map a column onto the same bank.
  localparam logic [RowPairBits-1:0] SwapRowA = 2'b01;
  localparam logic [RowPairBits-1:0] SwapRowB = 2'b10;

  // True when the row pattern calls for a half-row swap.
  function automatic logic row_swapped(input logic [RowPairBits-1:0] row_bits);
    logic swap;
    swap = (row_bits == SwapRowA) || (row_bits == SwapRowB);
    return swap;
  endfunction

endpackage

`default_nettype wire
